// File: logic/dma_tx_consts.svh
// DMA transmit path constants
`ifndef DMA_TX_CONSTS_SVH
`define DMA_TX_CONSTS_SVH

// ********************************************************************
// Widths
// ********************************************************************

// Stream id carried by every transfer
`define DMA_TX_SID_WIDTH   2
// Word address into the TCDM, 1024 words
`define DMA_TX_ADDR_WIDTH  10
// Beat count of one command, zero stands for 256
`define DMA_TX_LEN_WIDTH   8
// TCDM data word
`define DMA_TX_DATA_WIDTH  32

// ********************************************************************
// Depths
// ********************************************************************

// Tags of reads in flight
`define DMA_TX_SID_DEPTH   2
// Words waiting for the external port
`define DMA_TX_BUF_DEPTH   4

`endif

// File: logic/dma_tx_pkg.sv
// DMA transmit path types
`default_nettype none

`include "dma_tx_consts.svh"

package dma_tx_pkg;

   // Stream id of a transfer
   typedef logic [`DMA_TX_SID_WIDTH-1:0]  sid_t;

   // TCDM word address
   typedef logic [`DMA_TX_ADDR_WIDTH-1:0] tcdm_addr_t;

   // Beats in one transfer, zero means the full 256
   typedef logic [`DMA_TX_LEN_WIDTH-1:0]  beat_len_t;

   // One data word
   typedef logic [`DMA_TX_DATA_WIDTH-1:0] tx_word_t;

   // Response channel of the TCDM read initiator
   typedef enum logic {TRANS_RUN, TRANS_STALLED} tx_state_e;

   // Beat generator
   typedef enum logic {GEN_IDLE, GEN_BUSY} gen_state_e;

endpackage

`default_nettype wire

// File: logic/tx_beat_gen.sv
// Transfer command beat generator
`default_nettype none

module tx_beat_gen
   import dma_tx_pkg::*;
(
   input  wire logic       clk_i,
   input  wire logic       rst_ni,

   // Command port
   input  wire logic       cmd_req_i,
   input  wire tcdm_addr_t cmd_addr_i,
   input  wire beat_len_t  cmd_len_i,
   input  wire sid_t       cmd_sid_i,
   output logic            cmd_gnt_o,

   // Beat port toward the TCDM initiator
   output logic            beat_req_o,
   output tcdm_addr_t      beat_addr_o,
   output sid_t            beat_sid_o,
   output logic            beat_eop_o,
   input  wire logic       beat_gnt_i
);

   gen_state_e state_q, state_d;
   beat_len_t  remain_q;
   tcdm_addr_t addr_q;
   sid_t       sid_q;
   logic       beat_take;
   logic       last_beat;

   // Commands are only taken while idle
   assign cmd_gnt_o  = (state_q == GEN_IDLE) && cmd_req_i;

   assign beat_req_o = (state_q == GEN_BUSY);
   assign beat_take  = beat_req_o && beat_gnt_i;

   // One beat left, so the current one closes the packet
   assign last_beat  = (remain_q == beat_len_t'(1));
   assign beat_eop_o = last_beat;

   assign beat_addr_o = addr_q;
   assign beat_sid_o  = sid_q;

   // ********************************************************************
   // Control FSM
   // ********************************************************************

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         GEN_IDLE:
         begin
            if (cmd_gnt_o)
            begin
               state_d = GEN_BUSY;
            end
         end
         GEN_BUSY:
         begin
            // Back to idle once the final beat is granted
            if (beat_take && last_beat)
            begin
               state_d = GEN_IDLE;
            end
         end
         default:
         begin
            state_d = GEN_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         state_q  <= GEN_IDLE;
         remain_q <= '0;
      end
      else
      begin
         state_q <= state_d;
         // A length of zero counts down through 255 and so issues 256 beats
         if (cmd_gnt_o)
         begin
            remain_q <= cmd_len_i;
         end
         else if (beat_take)
         begin
            remain_q <= remain_q - 1'b1;
         end
      end
   end

   // Address and stream id of the running command
   always_ff @(posedge clk_i)
   begin
      if (cmd_gnt_o)
      begin
         addr_q <= cmd_addr_i;
         sid_q  <= cmd_sid_i;
      end
      else if (beat_take)
      begin
         // Wraps at the top of the TCDM
         addr_q <= addr_q + 1'b1;
      end
   end

   // Pending beat keeps its address and id until granted
   a_beat_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
      beat_req_o && !beat_gnt_i |=> $stable(beat_addr_o) && $stable(beat_sid_o));

endmodule

`default_nettype wire

// File: logic/tx_sid_fifo.sv
// Read tag queue
`default_nettype none

module tx_sid_fifo
   import dma_tx_pkg::*;
#(
   parameter int DEPTH = 2
)
(
   input  wire logic clk_i,
   input  wire logic rst_ni,

   // Tag of a granted read
   input  wire logic push_i,
   input  wire sid_t push_sid_i,
   input  wire logic push_eop_i,

   // Tag of the word being handed over
   input  wire logic pop_i,
   output sid_t      pop_sid_o,
   output logic      pop_eop_o
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   sid_t             sid_mem [DEPTH];
   logic             eop_mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             full, empty;

   // Circular pointer step, also for depths that are no power of two
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign full      = (count_q == CNT_W'(DEPTH));
   assign empty     = (count_q == '0);
   assign pop_sid_o = sid_mem[rd_ptr_q];
   assign pop_eop_o = eop_mem[rd_ptr_q];

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (push_i)
         begin
            wr_ptr_q <= next_ptr(wr_ptr_q);
         end
         if (pop_i)
         begin
            rd_ptr_q <= next_ptr(rd_ptr_q);
         end
         // Occupancy only moves when exactly one side acts
         if (push_i && !pop_i)
         begin
            count_q <= count_q + 1'b1;
         end
         else if (pop_i && !push_i)
         begin
            count_q <= count_q - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (push_i)
      begin
         sid_mem[wr_ptr_q] <= push_sid_i;
         eop_mem[wr_ptr_q] <= push_eop_i;
      end
   end

   a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
      push_i |-> !full);

   a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
      pop_i |-> !empty);

endmodule

`default_nettype wire

// File: logic/tcdm_tx_if.sv
// TCDM read initiator
`default_nettype none

`include "dma_tx_consts.svh"

module tcdm_tx_if
   import dma_tx_pkg::*;
(
   input  wire logic       clk_i,
   input  wire logic       rst_ni,

   // Beat port
   input  wire logic       beat_req_i,
   input  wire tcdm_addr_t beat_addr_i,
   input  wire sid_t       beat_sid_i,
   input  wire logic       beat_eop_i,
   output logic            beat_gnt_o,

   // TCDM read port
   output logic            tcdm_req_o,
   output tcdm_addr_t      tcdm_addr_o,
   input  wire logic       tcdm_gnt_i,
   input  wire tx_word_t   tcdm_r_rdata_i,
   input  wire logic       tcdm_r_valid_i,

   // Synchronization port
   output logic            synch_req_o,
   output sid_t            synch_sid_o,

   // Transmit data port
   output logic            tx_data_req_o,
   output tx_word_t        tx_data_dat_o,
   input  wire logic       tx_data_gnt_i
);

   tx_state_e state_q, state_d;
   tx_word_t  stall_q;
   logic      stall_sample;
   logic      trans_stalled;
   logic      tag_pop;
   sid_t      tag_sid;
   logic      tag_eop;

   // ********************************************************************
   // Request channel
   // ********************************************************************

   // No new read while a word is parked or about to be parked
   assign tcdm_req_o  = beat_req_i && !trans_stalled;
   assign tcdm_addr_o = beat_addr_i;

   // TCDM grant also grants the beat and queues its tag
   assign beat_gnt_o  = tcdm_req_o && tcdm_gnt_i;

   // ********************************************************************
   // Tags of reads in flight
   // ********************************************************************

   tx_sid_fifo #(
      .DEPTH      (`DMA_TX_SID_DEPTH)
   ) u_sid_fifo (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .push_i     (beat_gnt_o),
      .push_sid_i (beat_sid_i),
      .push_eop_i (beat_eop_i),
      .pop_i      (tag_pop),
      .pop_sid_o  (tag_sid),
      .pop_eop_o  (tag_eop)
   );

   // ********************************************************************
   // Response channel
   // ********************************************************************

   always_comb
   begin
      state_d       = state_q;
      tx_data_req_o = 1'b0;
      tag_pop       = 1'b0;
      stall_sample  = 1'b0;
      trans_stalled = 1'b0;
      case (state_q)
         TRANS_RUN:
         begin
            if (tcdm_r_valid_i)
            begin
               if (tx_data_gnt_i)
               begin
                  // Straight through in the response cycle
                  tx_data_req_o = 1'b1;
                  tag_pop       = 1'b1;
               end
               else
               begin
                  // Buffer full, park the word
                  stall_sample  = 1'b1;
                  trans_stalled = 1'b1;
                  state_d       = TRANS_STALLED;
               end
            end
         end
         TRANS_STALLED:
         begin
            trans_stalled = 1'b1;
            if (tx_data_gnt_i)
            begin
               tx_data_req_o = 1'b1;
               tag_pop       = 1'b1;
               state_d       = TRANS_RUN;
            end
         end
         default:
         begin
            state_d = TRANS_RUN;
         end
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         state_q <= TRANS_RUN;
      end
      else
      begin
         state_q <= state_d;
      end
   end

   // Stall register
   always_ff @(posedge clk_i)
   begin
      if (stall_sample)
      begin
         stall_q <= tcdm_r_rdata_i;
      end
   end

   // Parked word while stalled, live memory data otherwise
   assign tx_data_dat_o = (state_q == TRANS_STALLED) ? stall_q : tcdm_r_rdata_i;

   // End of packet reached the buffer
   assign synch_req_o = tag_pop && tag_eop;
   assign synch_sid_o = synch_req_o ? tag_sid : '0;

   // Memory answers every grant in the next cycle
   a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
      beat_gnt_o |=> tcdm_r_valid_i);

   // Requests are held back long enough that nothing returns while parked
   a_no_rvalid_stalled: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (state_q == TRANS_STALLED) |-> !tcdm_r_valid_i);

endmodule

`default_nettype wire

// File: logic/tx_data_buffer.sv
// Transmit output buffer
`default_nettype none

module tx_data_buffer
   import dma_tx_pkg::*;
#(
   parameter int DEPTH = 4
)
(
   input  wire logic     clk_i,
   input  wire logic     rst_ni,

   // Write side from the read path
   input  wire logic     tx_data_req_i,
   input  wire tx_word_t tx_data_dat_i,
   output logic          tx_data_gnt_o,

   // External transmit port
   output logic          ext_req_o,
   output tx_word_t      ext_data_o,
   input  wire logic     ext_gnt_i
);

   localparam int PTR_W = $clog2(DEPTH);
   localparam int CNT_W = $clog2(DEPTH + 1);

   tx_word_t         buf_mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
   logic [CNT_W-1:0] count_q;
   logic             wr_en, rd_en;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   // Grant is the not-full level
   assign tx_data_gnt_o = (count_q != CNT_W'(DEPTH));

   // Oldest word offered from storage, so no write-through when empty
   assign ext_req_o  = (count_q != '0);
   assign ext_data_o = buf_mem[rd_ptr_q];

   assign wr_en = tx_data_req_i;
   assign rd_en = ext_req_o && ext_gnt_i;

   always_ff @(posedge clk_i or negedge rst_ni)
   begin
      if (!rst_ni)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (wr_en)
         begin
            wr_ptr_q <= next_ptr(wr_ptr_q);
         end
         if (rd_en)
         begin
            rd_ptr_q <= next_ptr(rd_ptr_q);
         end
         if (wr_en && !rd_en)
         begin
            count_q <= count_q + 1'b1;
         end
         else if (rd_en && !wr_en)
         begin
            count_q <= count_q - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (wr_en)
      begin
         buf_mem[wr_ptr_q] <= tx_data_dat_i;
      end
   end

   a_no_write_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
      tx_data_req_i |-> tx_data_gnt_o);

endmodule

`default_nettype wire

// File: logic/dma_tx_top.sv
// DMA transmit read path
`default_nettype none

`include "dma_tx_consts.svh"

module dma_tx_top
   import dma_tx_pkg::*;
(
   input  wire logic       clk_i,
   input  wire logic       rst_ni,

   // Command port
   input  wire logic       cmd_req_i,
   input  wire tcdm_addr_t cmd_addr_i,
   input  wire beat_len_t  cmd_len_i,
   input  wire sid_t       cmd_sid_i,
   output logic            cmd_gnt_o,

   // TCDM read port
   output logic            tcdm_req_o,
   output tcdm_addr_t      tcdm_addr_o,
   input  wire logic       tcdm_gnt_i,
   input  wire tx_word_t   tcdm_r_rdata_i,
   input  wire logic       tcdm_r_valid_i,

   // Synchronization port
   output logic            synch_req_o,
   output sid_t            synch_sid_o,

   // External transmit port
   output logic            ext_req_o,
   output tx_word_t        ext_data_o,
   input  wire logic       ext_gnt_i
);

   // Beat port
   logic       beat_req;
   tcdm_addr_t beat_addr;
   sid_t       beat_sid;
   logic       beat_eop;
   logic       beat_gnt;

   // Transmit data port
   logic       tx_data_req;
   tx_word_t   tx_data_dat;
   logic       tx_data_gnt;

   tx_beat_gen u_beat_gen (
      .clk_i       (clk_i),
      .rst_ni      (rst_ni),
      .cmd_req_i   (cmd_req_i),
      .cmd_addr_i  (cmd_addr_i),
      .cmd_len_i   (cmd_len_i),
      .cmd_sid_i   (cmd_sid_i),
      .cmd_gnt_o   (cmd_gnt_o),
      .beat_req_o  (beat_req),
      .beat_addr_o (beat_addr),
      .beat_sid_o  (beat_sid),
      .beat_eop_o  (beat_eop),
      .beat_gnt_i  (beat_gnt)
   );

   tcdm_tx_if u_tcdm_tx_if (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .beat_req_i     (beat_req),
      .beat_addr_i    (beat_addr),
      .beat_sid_i     (beat_sid),
      .beat_eop_i     (beat_eop),
      .beat_gnt_o     (beat_gnt),
      .tcdm_req_o     (tcdm_req_o),
      .tcdm_addr_o    (tcdm_addr_o),
      .tcdm_gnt_i     (tcdm_gnt_i),
      .tcdm_r_rdata_i (tcdm_r_rdata_i),
      .tcdm_r_valid_i (tcdm_r_valid_i),
      .synch_req_o    (synch_req_o),
      .synch_sid_o    (synch_sid_o),
      .tx_data_req_o  (tx_data_req),
      .tx_data_dat_o  (tx_data_dat),
      .tx_data_gnt_i  (tx_data_gnt)
   );

   // Output buffer depth from the shared constants
   tx_data_buffer #(
      .DEPTH         (`DMA_TX_BUF_DEPTH)
   ) u_data_buffer (
      .clk_i         (clk_i),
      .rst_ni        (rst_ni),
      .tx_data_req_i (tx_data_req),
      .tx_data_dat_i (tx_data_dat),
      .tx_data_gnt_o (tx_data_gnt),
      .ext_req_o     (ext_req_o),
      .ext_data_o    (ext_data_o),
      .ext_gnt_i     (ext_gnt_i)
   );

endmodule

`default_nettype wire

// File: verif/tb_dma_tx.sv
// DMA transmit path testbench
`default_nettype none

`include "dma_tx_consts.svh"

module tb_dma_tx
   import dma_tx_pkg::*;
();

   logic       clk_i;
   logic       rst_ni;
   logic       cmd_req_i;
   tcdm_addr_t cmd_addr_i;
   beat_len_t  cmd_len_i;
   sid_t       cmd_sid_i;
   logic       cmd_gnt_o;
   logic       tcdm_req_o;
   tcdm_addr_t tcdm_addr_o;
   logic       tcdm_gnt_i;
   tx_word_t   tcdm_r_rdata_i;
   logic       tcdm_r_valid_i;
   logic       synch_req_o;
   sid_t       synch_sid_o;
   logic       ext_req_o;
   tx_word_t   ext_data_o;
   logic       ext_gnt_i;

   // One TCDM word per address
   tx_word_t   tcdm_mem [1 << `DMA_TX_ADDR_WIDTH];

   // Scoreboards
   tcdm_addr_t exp_addrs [$];
   tx_word_t   exp_words [$];
   sid_t       exp_sids [$];

   int         mismatch_errs = 0;
   int         other_errs = 0;
   int         cycle_cnt = 0;
   int         beats_total = 0;
   int         first_ext_cycle = -1;
   // Grant probabilities in percent
   int         gnt_pct = 100;
   int         ext_pct = 100;
   bit         ext_hold = 1'b0;

   dma_tx_top DUT (
      .clk_i          (clk_i),
      .rst_ni         (rst_ni),
      .cmd_req_i      (cmd_req_i),
      .cmd_addr_i     (cmd_addr_i),
      .cmd_len_i      (cmd_len_i),
      .cmd_sid_i      (cmd_sid_i),
      .cmd_gnt_o      (cmd_gnt_o),
      .tcdm_req_o     (tcdm_req_o),
      .tcdm_addr_o    (tcdm_addr_o),
      .tcdm_gnt_i     (tcdm_gnt_i),
      .tcdm_r_rdata_i (tcdm_r_rdata_i),
      .tcdm_r_valid_i (tcdm_r_valid_i),
      .synch_req_o    (synch_req_o),
      .synch_sid_o    (synch_sid_o),
      .ext_req_o      (ext_req_o),
      .ext_data_o     (ext_data_o),
      .ext_gnt_i      (ext_gnt_i)
   );

   initial
   begin
      clk_i = 1'b0;
      forever
      begin
         #4 clk_i = ~clk_i;
      end
   end

   always @(posedge clk_i)
   begin
      cycle_cnt <= cycle_cnt + 1;
   end

   // ********************************************************************
   // TCDM model and external sink
   // ********************************************************************

   // Grant sampled mid-cycle and answered one cycle later
   initial
   begin
      logic       rd_pending;
      tcdm_addr_t rd_addr;
      tcdm_gnt_i     = 1'b0;
      tcdm_r_valid_i = 1'b0;
      tcdm_r_rdata_i = '0;
      forever
      begin
         @(negedge clk_i);
         rd_pending = tcdm_req_o && tcdm_gnt_i;
         rd_addr    = tcdm_addr_o;
         @(posedge clk_i);
         #1;
         tcdm_r_valid_i = rd_pending;
         tcdm_r_rdata_i = rd_pending ? tcdm_mem[rd_addr] : '0;
         tcdm_gnt_i     = ($urandom % 100) < gnt_pct;
      end
   end

   initial
   begin
      ext_gnt_i = 1'b0;
      forever
      begin
         @(posedge clk_i);
         #1;
         ext_gnt_i = !ext_hold && (($urandom % 100) < ext_pct);
      end
   end

   // ********************************************************************
   // Checks and monitors
   // ********************************************************************

   task automatic check_addr(input tcdm_addr_t got, input tcdm_addr_t exp, input string what);
      if (got !== exp)
      begin
         mismatch_errs++;
         $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_word(input tx_word_t got, input tx_word_t exp, input string what);
      if (got !== exp)
      begin
         mismatch_errs++;
         $display("Fail %0t: %s got %h expected %h", $time, what, got, exp);
      end
   endtask

   task automatic check_sid(input sid_t got, input sid_t exp, input string what);
      if (got !== exp)
      begin
         mismatch_errs++;
         $display("Fail %0t: %s got %0d expected %0d", $time, what, got, exp);
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         mismatch_errs++;
         $display("Fail %0t: %s got %b expected %b", $time, what, got, exp);
      end
   endtask

   task automatic check_count(input int got, input int exp, input string what);
      if (got != exp)
      begin
         mismatch_errs++;
         $display("Fail %0t: %s got %0d expected %0d", $time, what, got, exp);
      end
   endtask

   // Each granted read goes to the next address of the running command
   always @(negedge clk_i)
   begin
      if (tcdm_req_o && tcdm_gnt_i)
      begin
         if (exp_addrs.size() == 0)
         begin
            other_errs++;
            $display("TCDM read of address %h was granted but none was expected",
                     tcdm_addr_o);
         end
         else
         begin
            check_addr(tcdm_addr_o, exp_addrs.pop_front(), "TCDM read address");
         end
      end
   end

   // A word leaves on ext_req_o and ext_gnt_i together
   always @(negedge clk_i)
   begin
      if (ext_req_o && first_ext_cycle < 0)
      begin
         first_ext_cycle = cycle_cnt;
      end
      if (ext_req_o && ext_gnt_i)
      begin
         if (exp_words.size() == 0)
         begin
            other_errs++;
            $display("Word %h left the external port but none was expected", ext_data_o);
         end
         else
         begin
            check_word(ext_data_o, exp_words.pop_front(), "external word");
         end
      end
   end

   always @(negedge clk_i)
   begin
      if (synch_req_o)
      begin
         if (exp_sids.size() == 0)
         begin
            other_errs++;
            $display("Synchronization pulse for sid %0d came with no open transfer",
                     synch_sid_o);
         end
         else
         begin
            check_sid(synch_sid_o, exp_sids.pop_front(), "synchronization sid");
         end
      end
   end

   // Limit grows with every commanded beat
   initial
   begin
      while (cycle_cnt < 20 * beats_total + 200)
      begin
         @(posedge clk_i);
      end
      $display("Timeout after %0d cycles, the DUT stopped moving data", cycle_cnt);
      $display("STATUS: FAIL");
      $finish;
   end

   // ********************************************************************
   // Stimulus helpers
   // ********************************************************************

   // Queues the expected reads, words and sid and then hands the command over
   task automatic send_cmd(input tcdm_addr_t addr, input beat_len_t len, input sid_t sid,
                           output int gnt_cycle);
      int beats;
      beats = (len == '0) ? 256 : int'(len);
      beats_total += beats;
      for (int i = 0; i < beats; i++)
      begin
         exp_addrs.push_back(tcdm_addr_t'(addr + i));
         exp_words.push_back(tcdm_mem[tcdm_addr_t'(addr + i)]);
      end
      exp_sids.push_back(sid);
      @(posedge clk_i);
      #1;
      cmd_req_i  = 1'b1;
      cmd_addr_i = addr;
      cmd_len_i  = len;
      cmd_sid_i  = sid;
      @(negedge clk_i);
      while (!cmd_gnt_o)
      begin
         @(negedge clk_i);
      end
      gnt_cycle = cycle_cnt;
      @(posedge clk_i);
      #1;
      cmd_req_i = 1'b0;
   endtask

   task automatic wait_drain();
      while (exp_addrs.size() != 0 || exp_words.size() != 0 || exp_sids.size() != 0)
      begin
         @(negedge clk_i);
      end
      // Room for stray words or pulses
      repeat (4) @(negedge clk_i);
   endtask

   // ********************************************************************
   // Directed tests
   // ********************************************************************

   task automatic test_reset_state();
      repeat (10)
      begin
         @(negedge clk_i);
         check_flag(cmd_gnt_o, 1'b0, "cmd_gnt_o after reset");
         check_flag(tcdm_req_o, 1'b0, "tcdm_req_o after reset");
         check_flag(synch_req_o, 1'b0, "synch_req_o after reset");
         check_flag(ext_req_o, 1'b0, "ext_req_o after reset");
      end
   endtask

   task automatic test_single_transfer();
      int gnt_cycle;
      first_ext_cycle = -1;
      send_cmd(10'h040, 8'd8, 2'd1, gnt_cycle);
      wait_drain();
      check_count(first_ext_cycle - gnt_cycle, 3, "first word latency");
   endtask

   task automatic test_back_to_back();
      int gnt_cycle;
      send_cmd(10'h100, 8'd5, 2'd0, gnt_cycle);
      // This one wraps past word 1023
      send_cmd(10'h3fc, 8'd9, 2'd3, gnt_cycle);
      send_cmd(10'h010, 8'd3, 2'd2, gnt_cycle);
      send_cmd(10'h2a0, 8'd12, 2'd1, gnt_cycle);
      wait_drain();
   endtask

   task automatic test_backpressure();
      int gnt_cycle;
      ext_hold = 1'b1;
      send_cmd(10'h200, 8'd16, 2'd2, gnt_cycle);
      repeat (10) @(negedge clk_i);
      // Buffer full and one word parked by now
      repeat (10)
      begin
         @(negedge clk_i);
         check_flag(tcdm_req_o, 1'b0, "tcdm_req_o while buffer full");
         check_flag(ext_req_o, 1'b1, "ext_req_o while buffer full");
      end
      ext_hold = 1'b0;
      wait_drain();
   endtask

   task automatic test_random_grants();
      int         gnt_cycle;
      tcdm_addr_t addr;
      beat_len_t  len;
      sid_t       sid;
      gnt_pct = 50;
      ext_pct = 30;
      repeat (6)
      begin
         addr = tcdm_addr_t'($urandom);
         len  = beat_len_t'(1 + ($urandom % 40));
         sid  = sid_t'($urandom);
         send_cmd(addr, len, sid, gnt_cycle);
      end
      wait_drain();
      gnt_pct = 100;
      ext_pct = 100;
   endtask

   task automatic test_edge_lengths();
      int gnt_cycle;
      send_cmd(10'h155, 8'd1, 2'd3, gnt_cycle);
      wait_drain();
      // Zero length stands for 256 beats
      send_cmd(10'h3c0, 8'd0, 2'd0, gnt_cycle);
      wait_drain();
   endtask

   // ********************************************************************
   // Main sequence
   // ********************************************************************

   initial
   begin
      void'($urandom(32'hc39a_adcc));
      rst_ni     = 1'b0;
      cmd_req_i  = 1'b0;
      cmd_addr_i = '0;
      cmd_len_i  = '0;
      cmd_sid_i  = '0;
      for (int a = 0; a < (1 << `DMA_TX_ADDR_WIDTH); a++)
      begin
         tcdm_mem[a] = $urandom;
      end
      repeat (2) @(posedge clk_i);
      #1;
      rst_ni = 1'b1;

      test_reset_state();
      test_single_transfer();
      test_back_to_back();
      test_backpressure();
      test_random_grants();
      test_edge_lengths();

      if (exp_addrs.size() != 0 || exp_words.size() != 0 || exp_sids.size() != 0)
      begin
         other_errs++;
         $display("Expected reads, words or pulses still outstanding at the end");
      end
      $display("Errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
      if (mismatch_errs == 0 && other_errs == 0)
      begin
         $display("STATUS: PASS");
      end
      else
      begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: project.f
+incdir+logic
logic/dma_tx_pkg.sv
logic/tx_beat_gen.sv
logic/tx_sid_fifo.sv
logic/tcdm_tx_if.sv
logic/tx_data_buffer.sv
logic/dma_tx_top.sv
verif/tb_dma_tx.sv

// File: Bender.yml
package:
  name: dma_tx

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/dma_tx_pkg.sv
      - logic/tx_beat_gen.sv
      - logic/tx_sid_fifo.sv
      - logic/tcdm_tx_if.sv
      - logic/tx_data_buffer.sv
      - logic/dma_tx_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - verif/tb_dma_tx.sv
